// ==== bench/sched_testdata.txt ====
# enqueue <queue> <length> | full <queue> <length> | idle
# queue 0..15 (port in upper bits), length in decimal bytes
enqueue 0 100
enqueue 1 64
enqueue 3 1
enqueue 2 200
enqueue 5 1500
enqueue 4 65
enqueue 7 128
enqueue 9 64
enqueue 13 300
enqueue 14 63
enqueue 3 129
enqueue 0 1000
idle
full 6 1500
enqueue 7 90
enqueue 6 64
enqueue 11 129
idle
enqueue 10 700
enqueue 15 2
idle

// ==== all.f ====
common/sched_pkg.sv
common/dq_notify_if.sv
scheduler/strict_prio_sched.sv
logic/queue_len_store.sv
logic/egress_shaper.sv
logic/egress_sched_top.sv
bench/egress_sched_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = egress_sched_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/egress_sched_tb.sv ====
// Reads bench/sched_testdata.txt from the project root; run the simulator from there.
// Reference model tracks queued lengths, partial bytes and per-port word spacing.
module egress_sched_tb;
    import sched_pkg::*;

    localparam int QUEUE_DEPTH  = 8;
    localparam int DRAIN_BYTES  = 8;
    localparam int QUIET_CYCLES = 64;
    localparam int IDLE_LIMIT   = 20000;

    logic        core_clk_ifc;
    logic        arst_n;
    logic        enq_valid;
    queue_id_t   enq_queue;
    blen_t       enq_blen;
    logic        enq_drop;
    logic        dq_valid;
    queue_id_t   dq_queue;
    word_bytes_t dq_bytes;
    logic        dq_last;

    // Model state per queue
    blen_t len_q   [NUM_QUEUES][$];
    // Cycle of the edge that took each packet in
    int    time_q  [NUM_QUEUES][$];
    blen_t partial [NUM_QUEUES];
    blen_t got_sum [NUM_QUEUES];
    int    prev_cycle  [NUM_PORTS];
    int    prev_charge [NUM_PORTS];

    int   cycle;
    int   value_errors;
    int   other_errors;
    logic traffic_started;
    logic timed_out;

    egress_sched_top #(
        .NUM_PORTS   ( NUM_PORTS   ),
        .QUEUE_DEPTH ( QUEUE_DEPTH ),
        .DRAIN_BYTES ( DRAIN_BYTES )
    ) i_egress_sched_top (
        .core_clk_ifc ( core_clk_ifc ),
        .arst_n       ( arst_n       ),
        .enq_valid    ( enq_valid    ),
        .enq_queue    ( enq_queue    ),
        .enq_blen     ( enq_blen     ),
        .enq_drop     ( enq_drop     ),
        .dq_valid     ( dq_valid     ),
        .dq_queue     ( dq_queue     ),
        .dq_bytes     ( dq_bytes     ),
        .dq_last      ( dq_last      )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #50 core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) begin
        cycle <= cycle + 1;
    end

    ///////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_queue(input string name, input queue_id_t got, input queue_id_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bytes(input string name, input word_bytes_t got, input word_bytes_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_blen(input string name, input blen_t got, input blen_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Output monitor

    task automatic take_word();
        int          port;
        int          qq;
        int          gap;
        logic        found;
        logic        exp_last;
        queue_id_t   exp_queue;
        blen_t       remain;
        word_bytes_t exp_bytes;
        port = int'(dq_queue) / QUEUES_PER_PORT;
        if (len_q[dq_queue].size() == 0) begin
            $display("Word seen on queue %0d, which holds no packet", dq_queue);
            other_errors++;
            return;
        end
        // A new packet comes from the highest queue the scheduler could see
        if (partial[dq_queue] == '0) begin
            found     = 1'b0;
            exp_queue = dq_queue;
            for (int pr = QUEUES_PER_PORT - 1; pr >= 0; pr--) begin
                qq = port * QUEUES_PER_PORT + pr;
                if (!found && len_q[qq].size() > 0 && cycle - time_q[qq][0] >= 3) begin
                    exp_queue = queue_id_t'(qq);
                    found     = 1'b1;
                end
            end
            check_queue("dq_queue", dq_queue, exp_queue);
        end
        remain    = len_q[dq_queue][0] - partial[dq_queue];
        exp_last  = (remain <= blen_t'(DATA_BYTES));
        exp_bytes = exp_last ? word_bytes_t'(remain) : word_bytes_t'(DATA_BYTES);
        check_bytes("dq_bytes", dq_bytes, exp_bytes);
        check_flag("dq_last", dq_last, exp_last);
        if (prev_cycle[port] >= 0) begin
            gap = cycle - prev_cycle[port];
            if (gap < prev_charge[port] / DRAIN_BYTES) begin
                $display("Port %0d words only %0d cycles apart, shaper needs %0d",
                         port, gap, prev_charge[port] / DRAIN_BYTES);
                other_errors++;
            end
        end
        prev_cycle[port]  = cycle;
        prev_charge[port] = int'(exp_bytes) + (exp_last ? OVERHEAD_BYTES : 0);
        partial[dq_queue] = partial[dq_queue] + blen_t'(exp_bytes);
        got_sum[dq_queue] = got_sum[dq_queue] + blen_t'(dq_bytes);
        if (exp_last) begin
            check_blen("packet length", got_sum[dq_queue], len_q[dq_queue][0]);
            void'(len_q[dq_queue].pop_front());
            void'(time_q[dq_queue].pop_front());
            partial[dq_queue] = '0;
            got_sum[dq_queue] = '0;
        end
    endtask

    always @(negedge core_clk_ifc) begin
        if (arst_n) begin
            if (!traffic_started) begin
                check_flag("dq_valid", dq_valid, 1'b0);
                check_flag("dq_last", dq_last, 1'b0);
                check_flag("enq_drop", enq_drop, 1'b0);
            end else if (dq_valid) begin
                take_word();
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic send_packet(input int q, input int len);
        logic exp_drop;
        traffic_started = 1'b1;
        enq_valid = 1'b1;
        enq_queue = queue_id_t'(q);
        enq_blen  = blen_t'(len);
        @(posedge core_clk_ifc);
        #10;
        enq_valid = 1'b0;
        // Model now holds every pop the accepting edge could count
        exp_drop = (len_q[q].size() >= QUEUE_DEPTH);
        if (!exp_drop) begin
            len_q[q].push_back(blen_t'(len));
            time_q[q].push_back(cycle);
        end
        check_flag("enq_drop", enq_drop, exp_drop);
    endtask

    task automatic wait_idle();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < QUIET_CYCLES && waited <= IDLE_LIMIT) begin
            @(negedge core_clk_ifc);
            waited++;
            quiet = dq_valid ? 0 : quiet + 1;
        end
        if (quiet < QUIET_CYCLES) begin
            $display("Timeout: output never went quiet after %0d cycles", waited);
            other_errors++;
            timed_out = 1'b1;
        end else begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (len_q[q].size() != 0) begin
                    $display("Queue %0d still holds %0d packets after idle",
                             q, len_q[q].size());
                    other_errors++;
                end
            end
        end
        @(posedge core_clk_ifc);
        #10;
    endtask

    initial begin
        int                fd;
        int                q;
        int                len;
        int                n;
        string             line;
        logic [8*16-1:0]   cmd;
        void'($urandom(93));
        arst_n          = 1'b0;
        enq_valid       = 1'b0;
        enq_queue       = '0;
        enq_blen        = '0;
        cycle           = 0;
        value_errors    = 0;
        other_errors    = 0;
        traffic_started = 1'b0;
        timed_out       = 1'b0;
        for (int i = 0; i < NUM_QUEUES; i++) begin
            partial[i] = '0;
            got_sum[i] = '0;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            prev_cycle[p]  = -1;
            prev_charge[p] = 0;
        end
        repeat (10) @(posedge core_clk_ifc);
        #10;
        arst_n = 1'b1;
        repeat (5) @(posedge core_clk_ifc);
        #10;
        fd = $fopen("bench/sched_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            other_errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                void'($fgets(line, fd));
                cmd = '0;
                n   = $sscanf(line, "%s %d %d", cmd, q, len);
                if (n < 1 || line.substr(0, 0) == "#") begin
                    continue;
                end
                if (cmd == "enqueue" && n == 3) begin
                    send_packet(q, len);
                    repeat ($urandom % 3) begin
                        @(posedge core_clk_ifc);
                        #10;
                    end
                end else if (cmd == "full" && n == 3) begin
                    // Fill past the depth so the last packet drops
                    for (int i = 0; i <= QUEUE_DEPTH; i++) begin
                        send_packet(q, len);
                    end
                end else if (cmd == "idle") begin
                    wait_idle();
                end else begin
                    $display("Unknown stimulus line: %s", line);
                    other_errors++;
                end
            end
            $fclose(fd);
        end
        if (!timed_out) begin
            wait_idle();
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== logic/egress_sched_top.sv ====
// Single clock domain. NUM_PORTS must fit the 2-bit port field of the queue id.
// Strobes carry no back-pressure; the only flow control is the internal shaper ready.
module egress_sched_top #(
    parameter int NUM_PORTS   = sched_pkg::NUM_PORTS,
    parameter int QUEUE_DEPTH = 8,
    parameter int DRAIN_BYTES = 8
) (
    input  logic                   core_clk_ifc,
    input  logic                   arst_n,
    input  logic                   enq_valid,
    input  sched_pkg::queue_id_t   enq_queue,
    input  sched_pkg::blen_t       enq_blen,
    output logic                   enq_drop,
    output logic                   dq_valid,
    output sched_pkg::queue_id_t   dq_queue,
    output sched_pkg::word_bytes_t dq_bytes,
    output logic                   dq_last
);
    import sched_pkg::*;

    if (NUM_PORTS < 1 || NUM_PORTS > 2**$bits(port_id_t)) begin : g_bad_ports
        $error("NUM_PORTS does not fit the port field of the queue id");
    end

    dq_notify_if notify_bus ();

    logic [NUM_QUEUES-1:0] queue_empty;
    logic [NUM_PORTS-1:0]  egr_ready;
    logic                  deq_valid;
    queue_id_t             deq_queue;

    queue_len_store #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) i_queue_len_store (
        .core_clk_ifc ( core_clk_ifc ),
        .arst_n       ( arst_n       ),
        .enq_valid    ( enq_valid    ),
        .enq_queue    ( enq_queue    ),
        .enq_blen     ( enq_blen     ),
        .enq_drop     ( enq_drop     ),
        .deq_valid    ( deq_valid    ),
        .deq_queue    ( deq_queue    ),
        .queue_empty  ( queue_empty  ),
        .notify       ( notify_bus   )
    );

    strict_prio_sched #(
        .NUM_PORTS ( NUM_PORTS )
    ) i_strict_prio_sched (
        .core_clk_ifc ( core_clk_ifc                                ),
        .arst_n       ( arst_n                                      ),
        .queue_empty  ( queue_empty[NUM_PORTS*QUEUES_PER_PORT-1:0]  ),
        .egr_ready    ( egr_ready                                   ),
        .deq_valid    ( deq_valid                                   ),
        .deq_queue    ( deq_queue                                   ),
        .notify       ( notify_bus                                  )
    );

    egress_shaper #(
        .NUM_PORTS   ( NUM_PORTS   ),
        .DRAIN_BYTES ( DRAIN_BYTES )
    ) i_egress_shaper (
        .core_clk_ifc ( core_clk_ifc ),
        .arst_n       ( arst_n       ),
        .notify       ( notify_bus   ),
        .egr_ready    ( egr_ready    )
    );

    // Notification also leaves the chip
    assign dq_valid = notify_bus.valid;
    assign dq_queue = notify_bus.queue;
    assign dq_bytes = notify_bus.bytes;
    assign dq_last  = notify_bus.last;

endmodule

// ==== logic/egress_shaper.sv ====
// Stands in for the egress buffers: a port is ready only once its byte credit has fully drained.
// DRAIN_BYTES must be nonzero.
module egress_shaper #(
    parameter int NUM_PORTS   = sched_pkg::NUM_PORTS,
    parameter int DRAIN_BYTES = 8
) (
    input  logic                 core_clk_ifc,
    input  logic                 arst_n,
    dq_notify_if.sink            notify,
    output logic [NUM_PORTS-1:0] egr_ready
);
    import sched_pkg::*;

    // Room for a few full words plus overhead
    localparam int ACC_W = 12;

    typedef logic [ACC_W-1:0] acc_t;

    port_id_t notify_port;

    assign notify_port = queue_port(notify.queue);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        acc_t acc;
        acc_t charge;
        acc_t acc_sum;
        acc_t acc_nxt;
        logic ready_q;

        always_comb begin
            charge = '0;
            if (notify.valid && notify_port == port_id_t'(p)) begin
                charge = acc_t'(notify.bytes);
                // Framing is charged once, on the last word
                if (notify.last) begin
                    charge = charge + acc_t'(OVERHEAD_BYTES);
                end
            end
            acc_sum = acc + charge;
            acc_nxt = (acc_sum > acc_t'(DRAIN_BYTES)) ? acc_sum - acc_t'(DRAIN_BYTES) : '0;
        end

        always_ff @(posedge core_clk_ifc or negedge arst_n) begin
            if (!arst_n) begin
                acc     <= '0;
                ready_q <= 1'b1;
            end else begin
                acc     <= acc_nxt;
                ready_q <= (acc_nxt == '0);
            end
        end

        assign egr_ready[p] = ready_q;
    end

    // Words only land on ports that were ready when the scheduler asked
    a_word_when_ready: assert property (
        @(posedge core_clk_ifc) disable iff (!arst_n)
        notify.valid |-> egr_ready[notify_port]
    );

endmodule

// ==== logic/queue_len_store.sv ====
// Answers every dequeue request with one word two cycles later; the caller must not ask empty queues.
// An enqueue to a full queue is dropped even if that queue pops in the same cycle.
module queue_len_store #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                             core_clk_ifc,
    input  logic                             arst_n,
    input  logic                             enq_valid,
    input  sched_pkg::queue_id_t             enq_queue,
    input  sched_pkg::blen_t                 enq_blen,
    output logic                             enq_drop,
    input  logic                             deq_valid,
    input  sched_pkg::queue_id_t             deq_queue,
    output logic [sched_pkg::NUM_QUEUES-1:0] queue_empty,
    dq_notify_if.source                      notify
);
    import sched_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    blen_t len_mem     [NUM_QUEUES][QUEUE_DEPTH];
    blen_t head_remain [NUM_QUEUES];
    ptr_t  wr_ptr      [NUM_QUEUES];
    ptr_t  rd_ptr      [NUM_QUEUES];
    cnt_t  queue_cnt   [NUM_QUEUES];

    logic                  enq_accept;
    logic [NUM_QUEUES-1:0] cnt_inc;
    logic [NUM_QUEUES-1:0] cnt_dec;

    // Request stage
    logic        s1_valid;
    queue_id_t   s1_queue;
    blen_t       s1_remain;
    logic        s1_last;
    word_bytes_t s1_bytes;
    logic        pop;
    ptr_t        pop_rd_nxt;

    function automatic ptr_t ptr_inc(input ptr_t ptr);
        return (ptr == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign enq_accept = enq_valid && (queue_cnt[enq_queue] != cnt_t'(QUEUE_DEPTH));

    // Head word: a full DATA_BYTES, or whatever is left with last set
    assign s1_remain  = head_remain[s1_queue];
    assign s1_last    = (s1_remain <= blen_t'(DATA_BYTES));
    assign s1_bytes   = s1_last ? word_bytes_t'(s1_remain) : word_bytes_t'(DATA_BYTES);
    assign pop        = s1_valid && s1_last;
    assign pop_rd_nxt = ptr_inc(rd_ptr[s1_queue]);

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            cnt_inc[q]     = enq_accept && enq_queue == queue_id_t'(q);
            cnt_dec[q]     = pop && s1_queue == queue_id_t'(q);
            queue_empty[q] = (queue_cnt[q] == '0);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Control state

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid     <= 1'b0;
            enq_drop     <= 1'b0;
            notify.valid <= 1'b0;
            notify.last  <= 1'b0;
            for (int q = 0; q < NUM_QUEUES; q++) begin
                wr_ptr[q]    <= '0;
                rd_ptr[q]    <= '0;
                queue_cnt[q] <= '0;
            end
        end else begin
            s1_valid     <= deq_valid;
            enq_drop     <= enq_valid && !enq_accept;
            notify.valid <= s1_valid;
            notify.last  <= pop;
            if (enq_accept) begin
                wr_ptr[enq_queue] <= ptr_inc(wr_ptr[enq_queue]);
            end
            if (pop) begin
                rd_ptr[s1_queue] <= pop_rd_nxt;
            end
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (cnt_inc[q] && !cnt_dec[q]) begin
                    queue_cnt[q] <= queue_cnt[q] + 1'b1;
                end else if (cnt_dec[q] && !cnt_inc[q]) begin
                    queue_cnt[q] <= queue_cnt[q] - 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lengths and head remainders

    always_ff @(posedge core_clk_ifc) begin
        s1_queue      <= deq_queue;
        notify.queue  <= s1_queue;
        notify.bytes  <= s1_bytes;
        if (enq_accept) begin
            len_mem[enq_queue][wr_ptr[enq_queue]] <= enq_blen;
        end
        // New packet into an empty queue becomes the head at once
        if (enq_accept && queue_cnt[enq_queue] == '0) begin
            head_remain[enq_queue] <= enq_blen;
        end
        if (s1_valid) begin
            if (!s1_last) begin
                head_remain[s1_queue] <= s1_remain - blen_t'(DATA_BYTES);
            end else if (queue_cnt[s1_queue] > cnt_t'(1)) begin
                head_remain[s1_queue] <= len_mem[s1_queue][pop_rd_nxt];
            end else if (enq_accept && enq_queue == s1_queue) begin
                head_remain[s1_queue] <= enq_blen;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks

    // First in-flight queue at or after the requested one
    logic [NUM_QUEUES-1:0] inflight_mask;
    int                    dup_prev;
    logic                  dup_hit;

    assign inflight_mask = s1_valid ? (NUM_QUEUES'(1) << s1_queue) : '0;
    assign dup_prev      = (int'(deq_queue) + NUM_QUEUES - 1) % NUM_QUEUES;
    assign dup_hit       = (rr_next(inflight_mask, dup_prev, NUM_QUEUES) == int'(deq_queue));

    a_no_dup_req: assert property (
        @(posedge core_clk_ifc) disable iff (!arst_n)
        deq_valid |-> !dup_hit
    );

    // Requested queue still holds a packet when its word is cut
    a_no_empty_pop: assert property (
        @(posedge core_clk_ifc) disable iff (!arst_n)
        deq_valid |=> !queue_empty[$past(deq_queue)]
    );

endmodule

// ==== scheduler/strict_prio_sched.sv ====
// Issues one dequeue request per cycle at most, and one in flight per port.
// Relies on the store answering every request exactly two cycles later.
module strict_prio_sched #(
    parameter int NUM_PORTS = sched_pkg::NUM_PORTS
) (
    input  logic                                            core_clk_ifc,
    input  logic                                            arst_n,
    input  logic [NUM_PORTS*sched_pkg::QUEUES_PER_PORT-1:0] queue_empty,
    input  logic [NUM_PORTS-1:0]                            egr_ready,
    output logic                                            deq_valid,
    output sched_pkg::queue_id_t                            deq_queue,
    dq_notify_if.sink                                       notify
);
    import sched_pkg::*;

    logic [NUM_PORTS-1:0] in_flight;
    logic [NUM_PORTS-1:0] pkt_busy;
    logic [NUM_PORTS-1:0] port_has_pkt;
    logic [NUM_PORTS-1:0] eligible;

    prio_t cur_prio    [NUM_PORTS];
    prio_t best_prio   [NUM_PORTS];
    prio_t port_choice [NUM_PORTS];

    port_id_t last_grant;
    port_id_t grant_port;
    port_id_t deq_port;
    port_id_t notify_port;
    logic     grant_any;

    //////////////////////////////////////////////////////////////////////
    // Per-port queue choice

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            best_prio[p]    = '0;
            port_has_pkt[p] = 1'b0;
            // Ascending scan, so the highest non-empty priority sticks
            for (int q = 0; q < QUEUES_PER_PORT; q++) begin
                if (!queue_empty[p*QUEUES_PER_PORT + q]) begin
                    best_prio[p]    = prio_t'(q);
                    port_has_pkt[p] = 1'b1;
                end
            end
            // A packet in progress holds its port until its last word
            port_choice[p] = pkt_busy[p] ? cur_prio[p] : best_prio[p];
            eligible[p]    = egr_ready[p] && !in_flight[p] && (pkt_busy[p] || port_has_pkt[p]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Round-robin across eligible ports

    assign grant_any   = |eligible;
    assign grant_port  = port_id_t'(rr_next(NUM_QUEUES'(eligible), int'(last_grant), NUM_PORTS));
    assign notify_port = queue_port(notify.queue);
    assign deq_port    = queue_port(deq_queue);

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            deq_valid  <= 1'b0;
            last_grant <= '0;
            in_flight  <= '0;
            pkt_busy   <= '0;
        end else begin
            deq_valid <= grant_any;
            if (grant_any) begin
                last_grant <= grant_port;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (grant_any && grant_port == port_id_t'(p)) begin
                    in_flight[p] <= 1'b1;
                    pkt_busy[p]  <= 1'b1;
                end else if (notify.valid && notify_port == port_id_t'(p)) begin
                    in_flight[p] <= 1'b0;
                    if (notify.last) begin
                        pkt_busy[p] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (grant_any) begin
            deq_queue              <= {grant_port, port_choice[grant_port]};
            cur_prio[grant_port]   <= port_choice[grant_port];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks

    // Queue status seen one cycle earlier must still hold at issue
    a_req_not_empty: assert property (
        @(posedge core_clk_ifc) disable iff (!arst_n)
        deq_valid |-> !queue_empty[deq_queue]
    );

    // Notification returns two cycles on, so the same port waits at least four
    a_one_in_flight: assert property (
        @(posedge core_clk_ifc) disable iff (!arst_n)
        deq_valid |=> !(deq_valid && deq_port == $past(deq_port))
            ##1 !(deq_valid && deq_port == $past(deq_port, 2))
            ##1 !(deq_valid && deq_port == $past(deq_port, 3))
    );

endmodule

// ==== common/dq_notify_if.sv ====
// One-cycle dequeue notification strobe with no back-pressure.
// The store is the only source; any number of sinks may listen.
interface dq_notify_if;
    import sched_pkg::*;

    // Strobe, high for exactly one cycle per word
    logic        valid;
    queue_id_t   queue;
    // Bytes in this word, DATA_BYTES unless last
    word_bytes_t bytes;
    logic        last;

    modport source (
        output valid,
        output queue,
        output bytes,
        output last
    );

    modport sink (
        input valid,
        input queue,
        input bytes,
        input last
    );

endinterface

// ==== common/sched_pkg.sv ====
// Queue ids carry the port above a 2-bit priority, so the 4-bit id limits the design to 4 ports.
// Packet lengths up to 2047 bytes are representable; zero is not a valid length.
package sched_pkg;

    localparam int NUM_PORTS       = 4;
    localparam int QUEUES_PER_PORT = 4;
    localparam int PRIO_BITS       = 2;
    localparam int NUM_QUEUES      = 16;
    localparam int DATA_BYTES      = 64;
    localparam int OVERHEAD_BYTES  = 20;

    typedef logic [3:0]           queue_id_t;
    typedef logic [1:0]           port_id_t;
    typedef logic [PRIO_BITS-1:0] prio_t;
    typedef logic [10:0]          blen_t;
    typedef logic [6:0]           word_bytes_t;

    // Port field of a queue id
    function automatic port_id_t queue_port(input queue_id_t queue);
        return port_id_t'(queue >> PRIO_BITS);
    endfunction

    // Next set index after last, wrapping at n
    // Returns last itself when nothing requests
    function automatic int rr_next(input logic [NUM_QUEUES-1:0] req, input int last, input int n);
        int idx;
        rr_next = last;
        // Walk from the far end so the nearest requester wins
        for (int i = NUM_QUEUES; i >= 1; i--) begin
            idx = last + i;
            if (idx >= n) begin
                idx = idx - n;
            end
            if (i <= n && req[idx]) begin
                rr_next = idx;
            end
        end
    endfunction

endpackage
